/* logic/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus widths
`define CPU_ADDR_W 16
`define CPU_DATA_W 8

// First opcode fetch after reset
`define CPU_RESET_PC 16'h0200

// High address byte for zero-page accesses
`define CPU_ZERO_PAGE 8'h00

// Positions of the flags in the status byte
`define CPU_FLAG_N 7
`define CPU_FLAG_V 6
`define CPU_FLAG_Z 1
`define CPU_FLAG_C 0

`endif

/* logic/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    `include "cpu_params.svh"

    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [`CPU_DATA_W-1:0] data_t;

    // Cycle states
    typedef enum logic [2:0] {
        FETCH,        // Opcode on the bus
        OPERAND,      // Second instruction byte
        HIGH_BYTE,    // Third byte of JMP
        ZP_ACCESS,    // Zero-page read or write
        BRANCH_LOW,   // Add offset to PCL
        BRANCH_HIGH   // Fix PCH after a page crossing
    } cpu_state_e;

    // ALU operation, same order as opcode bits 7:5
    typedef enum logic [2:0] {
        ALU_ORA,
        ALU_AND,
        ALU_EOR,
        ALU_ADC,
        ALU_STA,
        ALU_LDA,
        ALU_CMP,
        ALU_SBC
    } alu_op_e;

    // Source of the internal data bus
    typedef enum logic [2:0] {
        DB_NONE,
        DB_DATA_IN,
        DB_ALU,
        DB_A,
        DB_COUNT
    } db_src_e;

    typedef enum logic {
        ADR_PC,
        ADR_ZERO_PAGE
    } adr_src_e;

    // Register driven onto data_out
    typedef enum logic [1:0] {
        STORE_A,
        STORE_X,
        STORE_Y
    } store_src_e;

endpackage

`default_nettype wire

/* logic/cpu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_control
    import cpu_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic enable,
    input  wire data_t opcode,
    input  wire logic branch_taken,
    input  wire logic page_cross,
    output cpu_state_e state,
    output alu_op_e alu_op,
    output db_src_e db_src,
    output logic load_a,
    output logic load_x,
    output logic load_y,
    output logic set_n,
    output logic set_z,
    output logic set_c_alu,
    output logic set_c_opcode,
    output logic clear_v,
    output logic set_v_alu,
    output logic count_inc,
    output logic count_dec,
    output adr_src_e adr_src,
    output logic pc_increment,
    output logic pc_branch_low,
    output logic pc_branch_high,
    output logic pc_jump,
    output store_src_e store_src,
    output logic write_enable,
    output logic sync
);

    cpu_state_e next_state;

    // Opcode classes
    wire logic op_alu_zp  = opcode ==? 8'b???_001_01;                   // ORA..SBC $00
    wire logic op_alu_imm = (opcode ==? 8'b???_010_01) & (opcode != 8'h89);  // No STA #
    wire logic op_alu     = op_alu_zp | op_alu_imm;
    wire logic op_acc_out = op_alu & (opcode[7:5] != 3'b100) & (opcode[7:5] != 3'b110);
    wire logic op_cmp     = op_alu & (opcode[7:5] == 3'b110);
    wire logic op_adc_sbc = op_alu & (opcode ==? 8'b?11_???_??);         // ADC/SBC
    wire logic op_sta     = opcode == 8'h85;
    wire logic op_stx     = opcode == 8'h86;
    wire logic op_sty     = opcode == 8'h84;
    wire logic op_ldx     = opcode == 8'hA2;                            // LDX #
    wire logic op_ldy     = opcode == 8'hA0;                            // LDY #
    wire logic op_cpx     = opcode == 8'hE0;
    wire logic op_cpy     = opcode == 8'hC0;
    wire logic op_tax     = opcode == 8'hAA;
    wire logic op_tay     = opcode == 8'hA8;
    wire logic op_txa_tya = (opcode == 8'h8A) | (opcode == 8'h98);
    wire logic op_inx_dex = (opcode == 8'hE8) | (opcode == 8'hCA);
    wire logic op_iny_dey = (opcode == 8'hC8) | (opcode == 8'h88);
    wire logic op_inc     = (opcode == 8'hE8) | (opcode == 8'hC8);
    wire logic op_dec     = (opcode == 8'hCA) | (opcode == 8'h88);
    wire logic op_clc_sec = opcode ==? 8'b00?_110_00;                   // C from bit 5
    wire logic op_clv     = opcode == 8'hB8;
    wire logic op_branch  = opcode ==? 8'b???_100_00;
    wire logic op_jmp     = opcode == 8'h4C;

    wire logic op_store = op_sta | op_stx | op_sty;
    wire logic op_zp    = op_alu_zp | op_stx | op_sty;                  // STA is in op_alu_zp
    wire logic op_imm   = op_alu_imm | op_ldx | op_ldy | op_cpx | op_cpy;
    wire logic op_cmp_any = op_cmp | op_cpx | op_cpy;

    wire logic in_fetch = state == FETCH;

    // Register updates in FETCH act on the previous opcode
    always_comb
    begin
        alu_op = (op_cpx | op_cpy) ? ALU_CMP : alu_op_e'(opcode[7:5]);

        if (op_stx | op_cpx)
            store_src = STORE_X;              // Also feeds the ALU for CPX
        else if (op_sty | op_cpy)
            store_src = STORE_Y;
        else
            store_src = STORE_A;

        if (op_ldx | op_ldy)
            db_src = DB_DATA_IN;
        else if (op_tax | op_tay)
            db_src = DB_A;
        else if (op_txa_tya | op_inx_dex | op_iny_dey)
            db_src = DB_COUNT;
        else if (op_acc_out | op_cmp_any)
            db_src = DB_ALU;
        else
            db_src = DB_NONE;
    end

    assign load_a = in_fetch & (op_acc_out | op_txa_tya);
    assign load_x = in_fetch & (op_ldx | op_tax | op_inx_dex);
    assign load_y = in_fetch & (op_ldy | op_tay | op_iny_dey);
    assign set_n  = load_a | load_x | load_y | (in_fetch & op_cmp_any);
    assign set_z  = set_n;
    assign set_c_alu    = in_fetch & (op_adc_sbc | op_cmp_any);
    assign set_c_opcode = in_fetch & op_clc_sec;
    assign clear_v      = in_fetch & op_clv;
    assign set_v_alu    = in_fetch & op_adc_sbc;
    assign count_inc    = in_fetch & op_inc;
    assign count_dec    = in_fetch & op_dec;

    // Bus and PC control
    assign adr_src        = (state == ZP_ACCESS) ? ADR_ZERO_PAGE : ADR_PC;
    assign write_enable   = (state == ZP_ACCESS) & op_store;
    assign pc_branch_low  = state == BRANCH_LOW;
    assign pc_branch_high = state == BRANCH_HIGH;
    assign pc_jump        = state == HIGH_BYTE;
    assign sync           = in_fetch;

    always_comb
    begin
        pc_increment = 1'b0;
        next_state = FETCH;
        case (state)
            FETCH:
            begin
                pc_increment = 1'b1;
                next_state = OPERAND;
            end
            OPERAND:
            begin
                // Unknown opcodes fall through as one-byte no-ops
                pc_increment = op_imm | op_zp | op_branch | op_jmp;
                if (op_zp)
                    next_state = ZP_ACCESS;
                else if (op_jmp)
                    next_state = HIGH_BYTE;
                else if (op_branch & branch_taken)
                    next_state = BRANCH_LOW;
            end
            BRANCH_LOW:
                next_state = page_cross ? BRANCH_HIGH : FETCH;
            default:
                next_state = FETCH;           // HIGH_BYTE, ZP_ACCESS, BRANCH_HIGH
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            state <= FETCH;
        else if (enable)
            state <= next_state;
    end

endmodule

`default_nettype wire

/* logic/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_alu
    import cpu_pkg::*;
(
    input  wire data_t a_in,
    input  wire data_t b_in,
    input  wire logic c_in,
    input  wire alu_op_e op,
    output data_t result,
    output logic c_out,
    output logic v_out
);

    wire logic subtract = (op == ALU_CMP) | (op == ALU_SBC);   // Add the complement
    wire logic carry = (op == ALU_CMP) | c_in;                 // CMP ignores C

    wire data_t addend = subtract ? ~b_in : b_in;
    wire logic [8:0] sum = {1'b0, a_in} + {1'b0, addend} + 9'(carry);

    always_comb
    begin
        case (op)
            ALU_ORA: result = a_in | b_in;
            ALU_AND: result = a_in & b_in;
            ALU_EOR: result = a_in ^ b_in;
            ALU_LDA: result = b_in;
            ALU_STA: result = '0;              // Stores never use the ALU result
            default: result = sum[7:0];        // ADC, CMP, SBC
        endcase
    end

    assign c_out = sum[8];
    // Overflow when both inputs share a sign the result lacks
    assign v_out = (a_in[7] ^ sum[7]) & (addend[7] ^ sum[7]);

endmodule

`default_nettype wire

/* logic/cpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_regfile
    import cpu_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic enable,
    input  wire data_t data_in,
    input  wire data_t opcode,
    input  wire data_t alu_result,
    input  wire logic alu_c,
    input  wire logic alu_v,
    input  wire db_src_e db_src,
    input  wire logic load_a,
    input  wire logic load_x,
    input  wire logic load_y,
    input  wire logic set_n,
    input  wire logic set_z,
    input  wire logic set_c_alu,
    input  wire logic set_c_opcode,
    input  wire logic clear_v,
    input  wire logic set_v_alu,
    input  wire logic count_inc,
    input  wire logic count_dec,
    output data_t reg_a,
    output data_t reg_x,
    output data_t reg_y,
    output logic flag_c,
    output logic branch_taken
);

    data_t status;                         // N V - - - - Z C
    data_t db;
    data_t next_status;

    // Counter unit works on X for TXA/INX/DEX, on Y otherwise
    wire logic count_x = (opcode == 8'h8A) | (opcode == 8'hE8) | (opcode == 8'hCA);
    wire data_t count_in = count_x ? reg_x : reg_y;
    wire data_t count_out = count_in + {8{count_dec}} + 8'(count_inc);

    // Internal data bus
    always_comb
    begin
        case (db_src)
            DB_DATA_IN: db = data_in;
            DB_ALU:     db = alu_result;
            DB_A:       db = reg_a;
            DB_COUNT:   db = count_out;
            default:    db = '0;
        endcase
    end

    always_comb
    begin
        next_status = status;
        if (set_n)
            next_status[`CPU_FLAG_N] = db[7];
        if (set_z)
            next_status[`CPU_FLAG_Z] = db == '0;
        if (set_c_opcode)
            next_status[`CPU_FLAG_C] = opcode[5];   // CLC / SEC
        else if (set_c_alu)
            next_status[`CPU_FLAG_C] = alu_c;
        if (clear_v)
            next_status[`CPU_FLAG_V] = 1'b0;
        else if (set_v_alu)
            next_status[`CPU_FLAG_V] = alu_v;
    end

    // Branch flag picked by bits 7:6 as N, V, C, Z and compared with bit 5
    wire logic [3:0] branch_flags = {status[`CPU_FLAG_Z], status[`CPU_FLAG_C],
                                     status[`CPU_FLAG_V], status[`CPU_FLAG_N]};
    assign branch_taken = branch_flags[opcode[7:6]] == opcode[5];
    assign flag_c = status[`CPU_FLAG_C];

    always_ff @(posedge clock)
    begin
        if (reset)
            status <= '0;
        else if (enable)
            status <= next_status;
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            if (load_a)
                reg_a <= db;
            if (load_x)
                reg_x <= db;
            if (load_y)
                reg_y <= db;
        end
    end

endmodule

`default_nettype wire

/* logic/cpu_bus_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_bus_unit
    import cpu_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic enable,
    input  wire data_t data_in,
    input  wire cpu_state_e state,
    input  wire adr_src_e adr_src,
    input  wire logic pc_increment,
    input  wire logic pc_branch_low,
    input  wire logic pc_branch_high,
    input  wire logic pc_jump,
    input  wire store_src_e store_src,
    input  wire logic write_enable,
    input  wire data_t reg_a,
    input  wire data_t reg_x,
    input  wire data_t reg_y,
    output addr_t address,
    output data_t data_out,
    output data_t data_reg,
    output data_t opcode,
    output logic page_cross
);

    addr_t pc;
    addr_t next_pc;
    logic branch_back;                     // Offset of the taken branch was negative

    // Low byte sum, data_reg holds the branch offset in BRANCH_LOW
    wire logic [8:0] branch_sum = {1'b0, pc[7:0]} + {1'b0, data_reg};
    assign page_cross = branch_sum[8] ^ data_reg[7];
    wire data_t page_fix = branch_back ? 8'hFF : 8'h01;

    always_comb
    begin
        if (pc_jump)
            next_pc = {data_in, data_reg};                 // High byte arrives now
        else if (pc_branch_low)
            next_pc = {pc[15:8], branch_sum[7:0]};
        else if (pc_branch_high)
            next_pc = {pc[15:8] + page_fix, pc[7:0]};
        else
            next_pc = pc + addr_t'(pc_increment);
    end

    assign address = (adr_src == ADR_ZERO_PAGE) ? {`CPU_ZERO_PAGE, data_reg} : pc;

    always_comb
    begin
        case (store_src)
            STORE_X: data_out = reg_x;
            STORE_Y: data_out = reg_y;
            default: data_out = reg_a;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc <= `CPU_RESET_PC;
            opcode <= 8'hEA;               // NOP, nothing to write back
        end
        else if (enable)
        begin
            pc <= next_pc;
            if (state == FETCH)
                opcode <= data_in;
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            // After a write the stored byte stands in for the read
            data_reg <= write_enable ? data_out : data_in;
            if (pc_branch_low)
                branch_back <= data_reg[7];
        end
    end

endmodule

`default_nettype wire

/* logic/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

// data_in carries the byte of the current address by the closing clock edge
module cpu_core
    import cpu_pkg::*;
(
    input  wire logic clock,
    input  wire logic reset,
    input  wire logic enable,
    input  wire data_t data_in,
    output addr_t address,
    output data_t data_out,
    output logic write_enable,
    output logic sync
);

    cpu_state_e state;
    alu_op_e alu_op;
    db_src_e db_src;
    adr_src_e adr_src;
    store_src_e store_src;
    logic load_a, load_x, load_y;
    logic set_n, set_z, set_c_alu, set_c_opcode, clear_v, set_v_alu;
    logic count_inc, count_dec;
    logic pc_increment, pc_branch_low, pc_branch_high, pc_jump;
    logic branch_taken, page_cross, flag_c, alu_c, alu_v;
    data_t opcode, data_reg, alu_result, reg_a, reg_x, reg_y;

    cpu_control control (
        .clock, .reset, .enable, .opcode, .branch_taken, .page_cross,
        .state, .alu_op, .db_src, .load_a, .load_x, .load_y,
        .set_n, .set_z, .set_c_alu, .set_c_opcode, .clear_v, .set_v_alu,
        .count_inc, .count_dec, .adr_src,
        .pc_increment, .pc_branch_low, .pc_branch_high, .pc_jump,
        .store_src, .write_enable, .sync
    );

    // Store mux doubles as the ALU A input so CPX and CPY compare X and Y
    cpu_alu alu (
        .a_in(data_out), .b_in(data_reg), .c_in(flag_c), .op(alu_op),
        .result(alu_result), .c_out(alu_c), .v_out(alu_v)
    );

    cpu_regfile regfile (
        .clock, .reset, .enable, .data_in(data_reg), .opcode,
        .alu_result, .alu_c, .alu_v, .db_src, .load_a, .load_x, .load_y,
        .set_n, .set_z, .set_c_alu, .set_c_opcode, .clear_v, .set_v_alu,
        .count_inc, .count_dec, .reg_a, .reg_x, .reg_y, .flag_c, .branch_taken
    );

    cpu_bus_unit bus_unit (
        .clock, .reset, .enable, .data_in, .state, .adr_src,
        .pc_increment, .pc_branch_low, .pc_branch_high, .pc_jump,
        .store_src, .write_enable, .reg_a, .reg_x, .reg_y,
        .address, .data_out, .data_reg, .opcode, .page_cross
    );

endmodule

`default_nettype wire

/* sim/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int QUIET_CYCLES = 40;      // Idle cycles watched for stray writes at the end

    logic clock;
    logic reset;
    logic enable;
    data_t data_in;
    addr_t address;
    data_t data_out;
    logic write_enable;
    logic sync;

    data_t mem [0:(1 << `CPU_ADDR_W) - 1];  // 64 KB memory model
    addr_t exp_addr[$];                     // Expected stores in write order
    data_t exp_data[$];
    int program_bytes;
    int store_idx;                          // Next expected store

    cpu_core UUT (
        .clock, .reset, .enable, .data_in,
        .address, .data_out, .write_enable, .sync
    );

    always #4 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_address(input addr_t got, input addr_t want, input string what);
        if (got !== want)
            abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, want));
    endtask

    task automatic check_data(input data_t got, input data_t want, input string what);
        if (got !== want)
            abort_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, what, got, want));
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        if (got !== want)
            abort_run($sformatf("error at %0t ns: %s is %b, expected %b", $time, what, got, want));
    endtask

    // Program chunks go into memory, expected stores into the queues
    task automatic load_tests();
        int fd;
        int count;
        logic [31:0] tag;
        logic [8*100-1:0] line_buf;
        addr_t addr;
        data_t value;
        fd = $fopen("sim/cpu_tests.txt", "r");
        if (fd == 0)
            abort_run("could not open the test file sim/cpu_tests.txt");
        else
        begin
            while ($fscanf(fd, "%s", tag) == 1)
            begin
                if (tag == "#")
                    void'($fgets(line_buf, fd));        // Column notes
                else if (tag == "P")
                begin
                    void'($fscanf(fd, "%h %d", addr, count));
                    for (int k = 0; k < count; k++)
                    begin
                        void'($fscanf(fd, "%h", value));
                        mem[addr] = value;
                        addr = addr + 16'd1;
                    end
                    program_bytes += count;
                end
                else if (tag == "E")
                begin
                    void'($fscanf(fd, "%h %h", addr, value));
                    exp_addr.push_back(addr);
                    exp_data.push_back(value);
                end
            end
            $fclose(fd);
        end
    endtask

    // A write lands at the coming rising edge, so it is checked and mirrored now
    task automatic check_store();
        if (store_idx >= exp_addr.size())
            abort_run("a write appeared after the last expected store");
        else
        begin
            check_address(address, exp_addr[store_idx], "store address");
            check_data(data_out, exp_data[store_idx], "store data");
            mem[address] = data_out;
            store_idx++;
        end
    endtask

    initial
    begin
        int cycles;
        int limit;
        int quiet;
        logic en;
        logic first_seen;
        clock = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        data_in = '0;
        cycles = 0;
        quiet = 0;
        first_seen = 1'b0;
        store_idx = 0;
        program_bytes = 0;
        void'($urandom(32'h3bd5_c225));
        for (int i = 0; i < (1 << `CPU_ADDR_W); i++)
            mem[i] = data_t'(i ^ (i >> 8));              // Background bytes vary with the address
        load_tests();
        limit = 8 * program_bytes + 200;
        repeat (10) @(negedge clock);
        reset = 1'b0;
        while (cycles < limit && quiet < QUIET_CYCLES)
        begin
            en = ($urandom % 4) != 0;                    // Stall about a quarter of the cycles
            enable = en;
            data_in = mem[address];                      // Byte of the current address
            if (en && !first_seen)
            begin
                check_bit(sync, 1'b1, "sync in the first cycle");
                check_bit(write_enable, 1'b0, "write_enable in the first cycle");
                check_address(address, `CPU_RESET_PC, "first fetch address");
                first_seen = 1'b1;
            end
            if (en && write_enable)
                check_store();
            if (store_idx == exp_addr.size())
                quiet++;                                 // Program now spins on its last JMP
            @(negedge clock);
            cycles++;
        end
        if (quiet >= QUIET_CYCLES)
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d expected stores seen",
                                cycles, store_idx, exp_addr.size()));
    end

endmodule

`default_nettype wire

/* sim/cpu_tests.txt */
# P address count bytes   program chunk, count in decimal, address and bytes in hex
# E address value         expected store, in the order the writes happen
P 0200 12 A9 5A A2 C3 A0 7E 85 10 86 11 84 12
P 020C 15 09 81 29 F0 49 3C 85 13 18 69 25 69 10 85 14
P 021B 13 38 E9 30 E9 01 85 15 A5 13 65 14 85 16
P 0228 16 A2 FF E8 86 17 CA CA 8A A8 C8 C8 88 84 18 85 19
P 0238 10 A9 6B AA 86 1A A0 33 98 85 1B
P 0242 14 C5 1B F0 02 A9 E1 85 1C D0 02 A9 44 85 1D
P 0250 12 E0 70 90 02 A9 E2 30 02 A9 E3 85 1E
P 025C 15 A9 70 18 69 20 70 02 A9 E4 50 02 69 01 85 1F
P 026B 15 10 02 A9 08 10 02 A9 E6 85 20 4C F8 02 85 21
P 02F0 5 86 22 4C 14 03
P 02F8 4 A9 C7 30 10
P 030C 6 85 21 A2 00 F0 DE
P 0314 7 A9 3D 85 23 4C 18 03
E 0010 5A
E 0011 C3
E 0012 7E
E 0013 EC
E 0014 22
E 0015 F0
E 0016 0F
E 0017 00
E 0018 FF
E 0019 FE
E 001A 6B
E 001B 33
E 001C 33
E 001D 44
E 001E 44
E 001F 91
E 0020 08
E 0021 C7
E 0022 00
E 0023 3D

/* compile.f */
+incdir+logic
logic/cpu_pkg.sv
logic/cpu_control.sv
logic/cpu_alu.sv
logic/cpu_regfile.sv
logic/cpu_bus_unit.sv
logic/cpu_core.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, then decide on the log contents
rm -rf obj_dir sim.log &&
verilator --binary --timing -f compile.f --top-module cpu_tb -o cpu_sim &&
./obj_dir/cpu_sim > sim.log 2>&1 ||
echo "simulation build or run ended with an error"
cat sim.log 2>/dev/null
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
